//--- flist.f
+incdir+test
verilog/lstmPkg.sv
verilog/operandSequencer.sv
verilog/gateUnit.sv
verilog/cellUpdate.sv
verilog/lstmCell.sv
test/lstmCellTb.sv

//--- Bender.yml
package:
  name: lstm_cell

sources:
  - verilog/lstmPkg.sv
  - verilog/operandSequencer.sv
  - verilog/gateUnit.sv
  - verilog/cellUpdate.sv
  - verilog/lstmCell.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/lstmCellTb.sv

//--- test/lstmModel.svh
`ifndef LSTM_MODEL_SVH
`define LSTM_MODEL_SVH

fixed_t modelW [numGates][hiddenSize][numCols];
fixed_t modelC [hiddenSize];
fixed_t modelH [hiddenSize];

// Clamp into the signed 18 bit range
function automatic fixed_t saturate(input longint x);
    if (x > 131071)
        return fixed_t'(131071);
    else if (x < -131072)
        return fixed_t'(-131072);
    return fixed_t'(x);
endfunction

function automatic fixed_t mulQ(input fixed_t a, input fixed_t b);
    longint p;
    p = longint'(a) * longint'(b);
    return saturate(p >>> fracBits);
endfunction

// clamp(x/4 + 1/2, 0, 1), one is 2048
function automatic fixed_t sigmoidClamp(input fixed_t x);
    int t;
    t = (int'(x) >>> 2) + 1024;
    if (t < 0)
        return fixed_t'(0);
    else if (t > 2048)
        return fixed_t'(2048);
    return fixed_t'(t);
endfunction

function automatic fixed_t tanhClamp(input fixed_t x);
    if (x > 2048)
        return fixed_t'(2048);
    else if (x < -2048)
        return fixed_t'(-2048);
    return x;
endfunction

// Full products summed, one shift and saturation at the end
function automatic fixed_t gatePre(input int g, input int r, input inputVec_t x);
    longint sum;
    fixed_t operand;
    sum = 0;
    for (int c = 0; c < numCols; c++)
    begin
        if (c < inputSize)
            operand = x[c];
        else if (c < inputSize + hiddenSize)
            operand = modelH[c - inputSize];
        else
            operand = fixed_t'(2048);
        sum += longint'(operand) * longint'(modelW[g][r][c]);
    end
    return saturate(sum >>> fracBits);
endfunction

task automatic stepModel(input inputVec_t x);
    fixed_t pre [numGates][hiddenSize];
    fixed_t z;
    fixed_t i;
    fixed_t f;
    fixed_t o;
    // All gates see the old h
    for (int g = 0; g < numGates; g++)
    begin
        for (int r = 0; r < hiddenSize; r++)
        begin
            pre[g][r] = gatePre(g, r, x);
        end
    end
    for (int r = 0; r < hiddenSize; r++)
    begin
        z = tanhClamp(pre[gateZ][r]);
        i = sigmoidClamp(pre[gateI][r]);
        f = sigmoidClamp(pre[gateF][r]);
        o = sigmoidClamp(pre[gateO][r]);
        modelC[r] = saturate(longint'(mulQ(f, modelC[r])) + longint'(mulQ(i, z)));
        modelH[r] = mulQ(o, tanhClamp(modelC[r]));
    end
endtask

`endif

//--- test/lstmCellTb.sv
module lstmCellTb
    import lstmPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int numRandom = 40;
    localparam int numPoke = 10;
    localparam int numSat = 10;
    localparam int numReload = 5;
    localparam int numSamples = numRandom + numPoke + numSat + numReload;
    localparam int fullLoad = numGates * hiddenSize * numCols;
    localparam int numWrites = 2 * fullLoad + hiddenSize * numCols;
    localparam int timeoutCycles = numSamples * 16 + numWrites + 100;

    logic clock;
    logic reset;
    logic newSample;
    inputVec_t inputVec;
    weightWrite_t weightWrite;
    logic busy;
    logic dataoutReady;
    hiddenVec_t outputVec;

    `include "lstmModel.svh"

    lstmCell uut (
        .clock        (clock),
        .reset        (reset),
        .newSample    (newSample),
        .inputVec     (inputVec),
        .weightWrite  (weightWrite),
        .busy         (busy),
        .dataoutReady (dataoutReady),
        .outputVec    (outputVec)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic fixed_t randomFixed(input int span);
        return fixed_t'(int'($urandom_range(0, 2 * span)) - span);
    endfunction

    function automatic inputVec_t randomInput(input int span);
        inputVec_t v;
        for (int i = 0; i < inputSize; i++)
            v[i] = randomFixed(span);
        return v;
    endfunction

    task automatic writeWeight(input gateKind_e g, input int r, input int c, input fixed_t v);
        weightWrite.valid = 1'b1;
        weightWrite.gate = g;
        weightWrite.row = rowBits'(r);
        weightWrite.col = colBits'(c);
        weightWrite.value = v;
        @(posedge clock);
        #2;
        weightWrite.valid = 1'b0;
        modelW[g][r][c] = v;
    endtask

    task automatic loadGate(input gateKind_e g, input int span);
        for (int r = 0; r < hiddenSize; r++)
            for (int c = 0; c < numCols; c++)
                writeWeight(g, r, c, randomFixed(span));
    endtask

    task automatic checkOutputs();
        for (int r = 0; r < hiddenSize; r++)
        begin
            assert (outputVec[r] == modelH[r])
            else abortRun($sformatf("[FAIL] outputVec[%0d] got %h expected %h",
                r, outputVec[r], modelH[r]));
        end
    endtask

    task automatic idleCycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge clock);
            #2;
            assert (dataoutReady == 1'b0)
            else abortRun($sformatf("[FAIL] dataoutReady got %h expected 0 while idle",
                dataoutReady));
        end
    endtask

    // Accepted at the next edge with the result due 10 edges later
    task automatic runSample(input inputVec_t x, input bit poke);
        newSample = 1'b1;
        inputVec = x;
        @(posedge clock);
        #2;
        stepModel(x);
        newSample = 1'b0;
        inputVec = randomInput(131071);
        assert (busy == 1'b1)
        else abortRun($sformatf("[FAIL] busy got %h expected 1 after acceptance", busy));
        for (int k = 1; k <= 11; k++)
        begin
            @(posedge clock);
            #2;
            assert (dataoutReady == (k == 10))
            else abortRun($sformatf("[FAIL] dataoutReady got %h expected %h at edge %0d",
                dataoutReady, (k == 10), k));
            assert (busy == (k < 11))
            else abortRun($sformatf("[FAIL] busy got %h expected %h at edge %0d",
                busy, (k < 11), k));
            if (k == 10)
                checkOutputs();
            newSample = poke && (k < 11) && ($urandom_range(0, 2) == 0);
            if (newSample)
                inputVec = randomInput(131071);
        end
    endtask

    initial
    begin
        void'($urandom(78));
        reset = 1'b1;
        newSample = 1'b0;
        inputVec = '0;
        weightWrite = '0;
        for (int r = 0; r < hiddenSize; r++)
        begin
            modelC[r] = '0;
            modelH[r] = '0;
        end
        repeat (10) @(posedge clock);
        #2;
        reset = 1'b0;

        assert (busy == 1'b0)
        else abortRun($sformatf("[FAIL] busy got %h expected 0 after reset", busy));
        assert (dataoutReady == 1'b0)
        else abortRun($sformatf("[FAIL] dataoutReady got %h expected 0 after reset",
            dataoutReady));
        assert (outputVec == '0)
        else abortRun($sformatf("[FAIL] outputVec got %h expected 0 after reset", outputVec));

        for (int g = 0; g < numGates; g++)
            loadGate(gateKind_e'(g), 1024);
        for (int n = 0; n < numRandom; n++)
        begin
            runSample(randomInput(4096), 1'b0);
            idleCycles($urandom_range(0, 2));
        end

        // Extra newSample pulses while busy
        for (int n = 0; n < numPoke; n++)
            runSample(randomInput(4096), 1'b1);

        // Large weights and inputs drive the gates into saturation
        for (int g = 0; g < numGates; g++)
            loadGate(gateKind_e'(g), 131071);
        for (int n = 0; n < numSat; n++)
            runSample(randomInput(131071), 1'b1);

        loadGate(gateF, 1024);
        for (int n = 0; n < numReload; n++)
        begin
            runSample(randomInput(4096), 1'b0);
            idleCycles(1);
        end

        $display("Done: no errors");
        $finish;
    end

    initial
    begin
        #(timeoutCycles * 20);
        abortRun("Watchdog expired before all samples were checked");
    end

endmodule

//--- verilog/lstmCell.sv
module lstmCell
    import lstmPkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         newSample,
    input  inputVec_t    inputVec,
    input  weightWrite_t weightWrite,
    output logic         busy,
    output logic         dataoutReady,
    output hiddenVec_t   outputVec
);

    operandBeat_t beat;
    gateResult_t gateResults [numGates];
    hiddenVec_t hiddenState;

    operandSequencer sequencer (
        .clock        (clock),
        .reset        (reset),
        .newSample    (newSample),
        .inputVec     (inputVec),
        .hiddenState  (hiddenState),
        .dataoutReady (dataoutReady),
        .beat         (beat),
        .busy         (busy)
    );

    // Same beat stream drives all four gates
    for (genvar g = 0; g < numGates; g++)
    begin : gates
        gateUnit #(
            .gateIndex (gateKind_e'(g))
        ) unit (
            .clock       (clock),
            .reset       (reset),
            .beat        (beat),
            .weightWrite (weightWrite),
            .result      (gateResults[g])
        );
    end

    cellUpdate update (
        .clock        (clock),
        .reset        (reset),
        .zGate        (gateResults[gateZ]),
        .iGate        (gateResults[gateI]),
        .fGate        (gateResults[gateF]),
        .oGate        (gateResults[gateO]),
        .hiddenState  (hiddenState),
        .dataoutReady (dataoutReady)
    );

    assign outputVec = hiddenState;

endmodule

//--- verilog/cellUpdate.sv
module cellUpdate
    import lstmPkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  gateResult_t zGate,
    input  gateResult_t iGate,
    input  gateResult_t fGate,
    input  gateResult_t oGate,
    output hiddenVec_t  hiddenState,
    output logic        dataoutReady
);

    fixed_t zAct [hiddenSize];
    fixed_t iAct [hiddenSize];
    fixed_t fAct [hiddenSize];
    fixed_t oAct [hiddenSize];
    logic signed [accBits-1:0] cSum [hiddenSize];
    hiddenVec_t cState;
    hiddenVec_t hState;
    logic actValid;
    logic cellValid;

    // Stage one, activations
    always_ff @(posedge clock)
    begin
        if (zGate.valid)
        begin
            for (int r = 0; r < hiddenSize; r++)
            begin
                zAct[r] <= hardTanh(zGate.pre[r]);
                iAct[r] <= hardSigmoid(iGate.pre[r]);
                fAct[r] <= hardSigmoid(fGate.pre[r]);
                oAct[r] <= hardSigmoid(oGate.pre[r]);
            end
        end
    end

    // c = f*c + i*z
    always_comb
    begin
        for (int r = 0; r < hiddenSize; r++)
        begin
            cSum[r] = accBits'(fixMul(fAct[r], cState[r]))
                + accBits'(fixMul(iAct[r], zAct[r]));
        end
    end

    // Stage two, cell state
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            cState <= '0;
        end
        else if (actValid)
        begin
            for (int r = 0; r < hiddenSize; r++)
            begin
                cState[r] <= satFixed(cSum[r]);
            end
        end
    end

    // Stage three, h = o*tanh(c)
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            hState <= '0;
        end
        else if (cellValid)
        begin
            for (int r = 0; r < hiddenSize; r++)
            begin
                hState[r] <= fixMul(oAct[r], hardTanh(cState[r]));
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            actValid <= 1'b0;
            cellValid <= 1'b0;
            dataoutReady <= 1'b0;
        end
        else
        begin
            actValid <= zGate.valid;
            cellValid <= actValid;
            dataoutReady <= cellValid;
        end
    end

    assign hiddenState = hState;

    gateValidsAgree: assert property (@(posedge clock) disable iff (reset)
        (zGate.valid == iGate.valid) && (zGate.valid == fGate.valid)
        && (zGate.valid == oGate.valid));

endmodule

//--- verilog/gateUnit.sv
module gateUnit
    import lstmPkg::*;
#(
    parameter gateKind_e gateIndex = gateZ
)
(
    input  logic         clock,
    input  logic         reset,
    input  operandBeat_t beat,
    input  weightWrite_t weightWrite,
    output gateResult_t  result
);

    fixed_t weights [hiddenSize][numCols];
    logic signed [2*dataBits-1:0] product [hiddenSize];
    logic signed [accBits-1:0] acc [hiddenSize];
    logic signed [accBits-1:0] accNext [hiddenSize];
    logic weightHit;
    logic resultValid;
    hiddenVec_t resultPre;

    // Writes are broadcast, each unit keeps its own gate
    assign weightHit = weightWrite.valid && (weightWrite.gate == gateIndex);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int r = 0; r < hiddenSize; r++)
            begin
                for (int c = 0; c < numCols; c++)
                begin
                    weights[r][c] <= '0;
                end
            end
        end
        else if (weightHit)
        begin
            weights[weightWrite.row][weightWrite.col] <= weightWrite.value;
        end
    end

    // One multiplier per row
    always_comb
    begin
        for (int r = 0; r < hiddenSize; r++)
        begin
            product[r] = beat.value * weights[r][beat.col];
            if (beat.first)
                accNext[r] = accBits'(product[r]);
            else
                accNext[r] = acc[r] + accBits'(product[r]);
        end
    end

    always_ff @(posedge clock)
    begin
        if (beat.valid)
        begin
            for (int r = 0; r < hiddenSize; r++)
            begin
                acc[r] <= accNext[r];
            end
        end
    end

    // Bias column is last, so the sum is complete here
    always_ff @(posedge clock)
    begin
        if (beat.valid && beat.last)
        begin
            for (int r = 0; r < hiddenSize; r++)
            begin
                resultPre[r] <= satFixed(accNext[r] >>> fracBits);
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
            resultValid <= 1'b0;
        else
            resultValid <= beat.valid && beat.last;
    end

    always_comb
    begin
        result.valid = resultValid;
        result.pre = resultPre;
    end

    colInRange: assert property (@(posedge clock) disable iff (reset)
        beat.valid |-> (beat.col < colBits'(numCols)));

    noWriteDuringStream: assert property (@(posedge clock) disable iff (reset)
        !(weightWrite.valid && beat.valid));

endmodule

//--- verilog/operandSequencer.sv
module operandSequencer
    import lstmPkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         newSample,
    input  inputVec_t    inputVec,
    input  hiddenVec_t   hiddenState,
    input  logic         dataoutReady,
    output operandBeat_t beat,
    output logic         busy
);

    seqState_e state;
    logic [colBits-1:0] nextCol;
    logic [colBits-1:0] hidCol;
    inputVec_t inputReg;
    inputVec_t inputSrc;
    fixed_t nextValue;
    operandBeat_t issueBeat;

    // Column 0 leaves at the accepting edge, before inputReg holds the sample
    assign inputSrc = (state == seqIdle) ? inputVec : inputReg;
    assign hidCol = nextCol - colBits'(inputSize);

    always_comb
    begin
        if (nextCol < colBits'(inputSize))
            nextValue = inputSrc[nextCol[inIdxBits-1:0]];
        else if (nextCol < colBits'(inputSize + hiddenSize))
            nextValue = hiddenState[hidCol[rowBits-1:0]];
        else
            nextValue = fixOne;
    end

    always_comb
    begin
        issueBeat.valid = 1'b1;
        issueBeat.first = (nextCol == '0);
        issueBeat.last = (nextCol == colBits'(numCols - 1));
        issueBeat.col = nextCol;
        issueBeat.value = nextValue;
    end

    always_ff @(posedge clock)
    begin
        if (state == seqIdle && newSample)
            inputReg <= inputVec;
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= seqIdle;
            nextCol <= '0;
            beat <= '0;
        end
        else
        begin
            case (state)
                seqIdle:
                begin
                    if (newSample)
                    begin
                        beat <= issueBeat;
                        nextCol <= nextCol + 1'b1;
                        state <= seqIssue;
                    end
                end
                seqIssue:
                begin
                    if (beat.last)
                    begin
                        beat <= '0;
                        nextCol <= '0;
                        state <= seqWait;
                    end
                    else
                    begin
                        beat <= issueBeat;
                        nextCol <= nextCol + 1'b1;
                    end
                end
                seqWait:
                begin
                    // Result strobe from the cell update ends the timestep
                    if (dataoutReady)
                        state <= seqIdle;
                end
                default:
                begin
                    state <= seqIdle;
                end
            endcase
        end
    end

    assign busy = (state != seqIdle);

    beatOnlyInIssue: assert property (@(posedge clock) disable iff (reset)
        beat.valid |-> (state == seqIssue));

endmodule

//--- verilog/lstmPkg.sv
package lstmPkg;

    // Q6.11 numbers
    localparam int fracBits = 11;
    localparam int dataBits = 18;

    localparam int inputSize = 2;
    localparam int hiddenSize = 4;
    localparam int numGates = 4;
    // Inputs, then hidden state, then the bias column
    localparam int numCols = inputSize + hiddenSize + 1;
    localparam int colBits = 3;
    localparam int rowBits = 2;
    localparam int inIdxBits = $clog2(inputSize);
    localparam int accBits = 44;

    typedef logic signed [dataBits-1:0] fixed_t;
    typedef fixed_t [inputSize-1:0] inputVec_t;
    typedef fixed_t [hiddenSize-1:0] hiddenVec_t;

    localparam fixed_t fixOne = fixed_t'(1 << fracBits);
    localparam fixed_t fixMax = {1'b0, {(dataBits-1){1'b1}}};
    localparam fixed_t fixMin = {1'b1, {(dataBits-1){1'b0}}};

    typedef enum logic [1:0] {gateZ, gateI, gateF, gateO} gateKind_e;

    typedef enum logic [1:0] {seqIdle, seqIssue, seqWait} seqState_e;

    typedef struct packed {
        logic valid;
        logic first;
        logic last;
        logic [colBits-1:0] col;
        fixed_t value;
    } operandBeat_t;

    typedef struct packed {
        logic valid;
        gateKind_e gate;
        logic [rowBits-1:0] row;
        logic [colBits-1:0] col;
        fixed_t value;
    } weightWrite_t;

    typedef struct packed {
        logic valid;
        hiddenVec_t pre;
    } gateResult_t;

    function automatic fixed_t satFixed(input logic signed [accBits-1:0] x);
        if (x > fixMax)
            return fixMax;
        else if (x < fixMin)
            return fixMin;
        return fixed_t'(x);
    endfunction

    function automatic fixed_t fixMul(input fixed_t a, input fixed_t b);
        logic signed [2*dataBits-1:0] prod;
        prod = a * b;
        return satFixed(accBits'(prod >>> fracBits));
    endfunction

    // clamp(x/4 + 1/2, 0, 1)
    function automatic fixed_t hardSigmoid(input fixed_t x);
        fixed_t t;
        t = (x >>> 2) + (fixOne >>> 1);
        if (t < 0)
            return '0;
        else if (t > fixOne)
            return fixOne;
        return t;
    endfunction

    function automatic fixed_t hardTanh(input fixed_t x);
        if (x > fixOne)
            return fixOne;
        else if (x < -fixOne)
            return -fixOne;
        return x;
    endfunction

endpackage
